//--- project.f
hw/cpu_regs_pkg.sv
hw/modrm_pkg.sv
hw/byte_fifo.sv
hw/immediate_reader.sv
hw/address_regfile.sv
hw/modrm_decode.sv
hw/modrm_unit.sv
testbench/modrm_checker.sv
testbench/modrm_tb.sv
+incdir+hw

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module modrm_tb \
    -f project.f -o modrm_sim
./obj_dir/modrm_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- testbench/modrm_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "modrm_consts.svh"

module modrm_tb
    import cpu_regs_pkg::*;
    import modrm_pkg::*;
();

    localparam int NUM_TESTS     = 6;
    localparam int OPS_PER_TEST  = 40;
    localparam int CYCLES_PER_OP = 40;
    localparam int CLK_PERIOD    = 20;
    localparam int TIMEOUT_NS    = NUM_TESTS * OPS_PER_TEST * CYCLES_PER_OP * CLK_PERIOD;

    logic                   clk;
    logic                   reset;
    logic                   wr_en;
    logic [`BYTE_WIDTH-1:0] wr_data;
    logic                   full;
    logic                   reg_wr_en;
    reg_num_t               reg_wr_sel;
    logic [`ADDR_WIDTH-1:0] reg_wr_data;
    logic                   start;
    logic                   busy;
    logic                   complete;
    logic [`ADDR_WIDTH-1:0] effective_address;
    reg_num_t               regnum;
    logic                   rm_is_reg;
    reg_num_t               rm_regnum;
    logic                   bp_as_base;
    logic [3:0]             test_id;
    logic                   test_done;
    logic                   run_done;
    int                     error_count;
    int                     check_count;
    int                     op_count;
    logic [31:0]            lfsr_state;

    modrm_unit u_dut (
        .clk               (clk),
        .reset             (reset),
        .wr_en             (wr_en),
        .wr_data           (wr_data),
        .full              (full),
        .reg_wr_en         (reg_wr_en),
        .reg_wr_sel        (reg_wr_sel),
        .reg_wr_data       (reg_wr_data),
        .start             (start),
        .busy              (busy),
        .complete          (complete),
        .effective_address (effective_address),
        .regnum            (regnum),
        .rm_is_reg         (rm_is_reg),
        .rm_regnum         (rm_regnum),
        .bp_as_base        (bp_as_base)
    );

    modrm_checker u_checker (
        .clk               (clk),
        .reset             (reset),
        .wr_en             (wr_en),
        .wr_data           (wr_data),
        .full              (full),
        .reg_wr_en         (reg_wr_en),
        .reg_wr_sel        (reg_wr_sel),
        .reg_wr_data       (reg_wr_data),
        .start             (start),
        .busy              (busy),
        .complete          (complete),
        .effective_address (effective_address),
        .regnum            (regnum),
        .rm_is_reg         (rm_is_reg),
        .rm_regnum         (rm_regnum),
        .bp_as_base        (bp_as_base),
        .test_id           (test_id),
        .test_done         (test_done),
        .run_done          (run_done),
        .error_count       (error_count),
        .check_count       (check_count),
        .op_count          (op_count)
    );

    // galois form, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int disp_bytes(input logic [7:0] b);
        case (b[7:6])
            2'b00:   return (b[2:0] == 3'b110) ? 2 : 0; // direct address.
            2'b01:   return 1;
            2'b10:   return 2;
            default: return 0;
        endcase
    endfunction

    function automatic logic [7:0] make_modrm(input int test);
        logic [1:0] mod;
        logic [2:0] reg_op;
        logic [2:0] rm;
        reg_op = 3'(rand_bits(3));
        rm     = 3'(rand_bits(3));
        case (test)
            1: mod = MOD_REG;
            2: begin
                mod = MOD_MEM;
                while (rm == RM_DIRECT) begin
                    rm = 3'(rand_bits(3));
                end
            end
            3: begin
                mod = MOD_MEM;
                rm  = RM_DIRECT;
            end
            4: mod = MOD_DISP8;
            5: mod = MOD_DISP16;
            default: mod = 2'(rand_bits(2));
        endcase
        return {mod, reg_op, rm};
    endfunction

    task automatic write_reg(input logic [2:0] sel, input logic [15:0] data);
        @(posedge clk);
        reg_wr_en   <= 1'b1;
        reg_wr_sel  <= sel;
        reg_wr_data <= data;
        @(posedge clk);
        reg_wr_en <= 1'b0;
    endtask

    task automatic push_byte(input logic [7:0] data, input int gap);
        repeat (gap) begin
            @(posedge clk);
            wr_en <= 1'b0;
        end
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_data <= data;
    endtask

    task automatic run_op(input logic [7:0] modrm_byte, input int gap_bits);
        int n_disp;
        n_disp = disp_bytes(modrm_byte);
        @(posedge clk);
        start <= 1'b1;
        push_byte(modrm_byte, int'(rand_bits(gap_bits)));
        for (int i = 0; i < n_disp; i++) begin
            push_byte(8'(rand_bits(8)), int'(rand_bits(gap_bits)));
        end
        @(posedge clk);
        wr_en <= 1'b0;
        do begin
            @(negedge clk);
        end while (!complete);
        @(posedge clk);
        start <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns without finishing the tests", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        wr_en       = 1'b0;
        wr_data     = '0;
        reg_wr_en   = 1'b0;
        reg_wr_sel  = AX;
        reg_wr_data = '0;
        start       = 1'b0;
        test_id     = '0;
        test_done   = 1'b0;
        run_done    = 1'b0;
        lfsr_state  = 32'hfa8a;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        for (int t = 1; t <= NUM_TESTS; t++) begin
            @(posedge clk);
            test_id <= 4'(t);
            for (int r = 0; r < 8; r++) begin
                write_reg(3'(r), rand_bits(16));
            end
            for (int op = 0; op < OPS_PER_TEST; op++) begin
                if (t == 6) begin
                    write_reg(3'(rand_bits(3)), rand_bits(16));
                end
                run_op(make_modrm(t), (t == 5) ? 3 : 2); // long gaps in test 5.
            end
            @(posedge clk);
            test_done <= 1'b1;
            @(posedge clk);
            test_done <= 1'b0;
        end

        @(posedge clk);
        run_done <= 1'b1;
        @(posedge clk);
        run_done <= 1'b0;
        @(posedge clk);
        if (error_count == 0 && check_count > 0 && op_count == NUM_TESTS * OPS_PER_TEST) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/modrm_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "modrm_consts.svh"

module modrm_checker
    import cpu_regs_pkg::*;
    import modrm_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   wr_en,
    input  wire logic [`BYTE_WIDTH-1:0] wr_data,
    input  wire logic                   full,
    input  wire logic                   reg_wr_en,
    input  wire reg_num_t               reg_wr_sel,
    input  wire logic [`ADDR_WIDTH-1:0] reg_wr_data,
    input  wire logic                   start,
    input  wire logic                   busy,
    input  wire logic                   complete,
    input  wire logic [`ADDR_WIDTH-1:0] effective_address,
    input  wire reg_num_t               regnum,
    input  wire logic                   rm_is_reg,
    input  wire reg_num_t               rm_regnum,
    input  wire logic                   bp_as_base,
    input  wire logic [3:0]             test_id,
    input  wire logic                   test_done,
    input  wire logic                   run_done,
    output int                          error_count,
    output int                          check_count,
    output int                          op_count
);

    logic [`ADDR_WIDTH-1:0] model_regs [8];
    logic [`BYTE_WIDTH-1:0] model_bytes [$];
    int                     test_errors;
    int                     test_checks;
    int                     test_ops;

    initial begin
        error_count = 0;
        check_count = 0;
        op_count    = 0;
        test_errors = 0;
        test_checks = 0;
        test_ops    = 0;
    end

    function automatic int disp_len(input modrm_t m);
        if (m.mod == 2'b01) return 1;
        if (m.mod == 2'b10) return 2;
        if (m.mod == 2'b00 && m.rm == 3'b110) return 2; // direct address.
        return 0;
    endfunction

    function automatic logic [`ADDR_WIDTH-1:0] base_sum(input logic [2:0] rm);
        case (rm)
            3'd0:    return model_regs[BX] + model_regs[SI];
            3'd1:    return model_regs[BX] + model_regs[DI];
            3'd2:    return model_regs[BP] + model_regs[SI];
            3'd3:    return model_regs[BP] + model_regs[DI];
            3'd4:    return model_regs[SI];
            3'd5:    return model_regs[DI];
            3'd6:    return model_regs[BP];
            default: return model_regs[BX];
        endcase
    endfunction

    task automatic report(input string what);
        $display("Error at %0t ns: %s", $time, what);
        error_count++;
        test_errors++;
    endtask

    task automatic compare(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_operand();
        modrm_t                 m;
        int                     need;
        logic [`ADDR_WIDTH-1:0] disp;
        logic [`ADDR_WIDTH-1:0] addr;
        op_count++;
        test_ops++;
        m    = modrm_t'((model_bytes.size() > 0) ? model_bytes[0] : 8'h00);
        need = (model_bytes.size() > 0) ? 1 + disp_len(m) : 1;
        if (model_bytes.size() < need) begin
            report("complete came before the operand bytes were queued");
        end else begin
            void'(model_bytes.pop_front());
            disp = '0;
            if (need == 2) begin
                disp = {{8{model_bytes[0][7]}}, model_bytes[0]}; // sign-extended.
            end else if (need == 3) begin
                disp = {model_bytes[1], model_bytes[0]}; // low byte first.
            end
            repeat (need - 1) void'(model_bytes.pop_front());

            compare("rm_is_reg", 16'(m.mod == 2'b11), 16'(rm_is_reg));
            compare("regnum", 16'(m.reg_op), 16'(regnum));
            compare("rm_regnum", 16'(m.rm), 16'(rm_regnum));
            compare("bp_as_base", 16'(m.rm inside {3'd2, 3'd3, 3'd6}), 16'(bp_as_base));
            if (m.mod != 2'b11) begin
                if (m.mod == 2'b00 && m.rm == 3'b110) begin
                    addr = disp;
                end else begin
                    addr = base_sum(m.rm) + disp; // wraps at 16 bits.
                end
                compare("effective_address", addr, effective_address);
            end
        end
    endtask

    // inputs change on the rising edge, so look at the falling one.
    always @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                model_regs[i] = '0;
            end
            model_bytes.delete();
        end else begin
            compare("busy", 16'(start), 16'(busy)); // start drops right after complete.
            if (complete && !start) begin
                report("complete arrived while start was low");
            end
            if (complete) begin
                check_operand();
            end
            if (reg_wr_en) begin
                model_regs[reg_wr_sel] = reg_wr_data;
            end
            if (wr_en) begin
                compare("full", 16'h0, 16'(full)); // at most three bytes queued.
                model_bytes.push_back(wr_data);
            end
            if (test_done) begin
                $display("test %0d: %0d operations, %0d checks, %0d errors",
                         test_id, test_ops, test_checks, test_errors);
                test_ops    = 0;
                test_checks = 0;
                test_errors = 0;
            end
            if (run_done) begin
                $display("total: %0d operations, %0d checks, %0d errors",
                         op_count, check_count, error_count);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/modrm_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "modrm_consts.svh"

module modrm_unit
    import cpu_regs_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   wr_en,
    input  wire logic [`BYTE_WIDTH-1:0] wr_data,
    output logic                        full,
    input  wire logic                   reg_wr_en,
    input  wire reg_num_t               reg_wr_sel,
    input  wire logic [`ADDR_WIDTH-1:0] reg_wr_data,
    input  wire logic                   start,
    output logic                        busy,
    output logic                        complete,
    output logic [`ADDR_WIDTH-1:0]      effective_address,
    output reg_num_t                    regnum,
    output logic                        rm_is_reg,
    output reg_num_t                    rm_regnum,
    output logic                        bp_as_base
);

    logic                   fifo_rd_en;
    logic                   dec_rd_en;
    logic                   imm_rd_en;
    logic [`BYTE_WIDTH-1:0] fifo_rd_data;
    logic                   fifo_empty;
    reg_num_t               reg_sel_base;
    reg_num_t               reg_sel_index;
    logic [`ADDR_WIDTH-1:0] regs_base;
    logic [`ADDR_WIDTH-1:0] regs_index;
    logic                   immed_start;
    logic                   immed_is_8bit;
    logic                   immed_complete;
    logic [`ADDR_WIDTH-1:0] immediate;

    assign fifo_rd_en = dec_rd_en | imm_rd_en; // never both at once.

    byte_fifo u_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .full    (full),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty)
    );

    address_regfile u_regfile (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (reg_wr_en),
        .wr_sel    (reg_wr_sel),
        .wr_data   (reg_wr_data),
        .sel_base  (reg_sel_base),
        .sel_index (reg_sel_index),
        .rd_base   (regs_base),
        .rd_index  (regs_index)
    );

    immediate_reader u_immed (
        .clk          (clk),
        .reset        (reset),
        .start        (immed_start),
        .is_8bit      (immed_is_8bit),
        .fifo_rd_en   (imm_rd_en),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty),
        .complete     (immed_complete),
        .immediate    (immediate)
    );

    modrm_decode u_decode (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .busy              (busy),
        .complete          (complete),
        .effective_address (effective_address),
        .regnum            (regnum),
        .rm_regnum         (rm_regnum),
        .rm_is_reg         (rm_is_reg),
        .bp_as_base        (bp_as_base),
        .reg_sel_base      (reg_sel_base),
        .reg_sel_index     (reg_sel_index),
        .regs_base         (regs_base),
        .regs_index        (regs_index),
        .fifo_rd_en        (dec_rd_en),
        .fifo_rd_data      (fifo_rd_data),
        .fifo_empty        (fifo_empty),
        .immed_start       (immed_start),
        .immed_is_8bit     (immed_is_8bit),
        .immed_complete    (immed_complete),
        .immediate         (immediate)
    );

endmodule

`default_nettype wire

//--- hw/modrm_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "modrm_consts.svh"

module modrm_decode
    import cpu_regs_pkg::*;
    import modrm_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   start,
    output logic                        busy,
    output logic                        complete,
    output logic [`ADDR_WIDTH-1:0]      effective_address,
    output reg_num_t                    regnum,
    output reg_num_t                    rm_regnum,
    output logic                        rm_is_reg,
    output logic                        bp_as_base,
    output reg_num_t                    reg_sel_base,
    output reg_num_t                    reg_sel_index,
    input  wire logic [`ADDR_WIDTH-1:0] regs_base,
    input  wire logic [`ADDR_WIDTH-1:0] regs_index,
    output logic                        fifo_rd_en,
    input  wire logic [`BYTE_WIDTH-1:0] fifo_rd_data,
    input  wire logic                   fifo_empty,
    output logic                        immed_start,
    output logic                        immed_is_8bit,
    input  wire logic                   immed_complete,
    input  wire logic [`ADDR_WIDTH-1:0] immediate
);

    modrm_t modrm;
    logic   have_modrm;
    logic   popped;
    logic   has_immediate;

    assign fifo_rd_en = start && !have_modrm && !fifo_empty;

    assign busy     = start || have_modrm;
    assign complete = have_modrm && (!has_immediate || immed_complete);

    assign immed_start   = popped && has_immediate; // one pulse per operand.
    assign immed_is_8bit = modrm.mod == MOD_DISP8;

    assign regnum     = modrm.reg_op;
    assign rm_regnum  = modrm.rm;
    assign rm_is_reg  = modrm.mod == MOD_REG;
    assign bp_as_base = reg_sel_base == BP;

    always_comb begin
        case (modrm.mod)
            MOD_MEM:               has_immediate = modrm.rm == RM_DIRECT;
            MOD_DISP8, MOD_DISP16: has_immediate = 1'b1;
            default:               has_immediate = 1'b0;
        endcase
    end

    always_comb begin
        case (modrm.rm)
            3'b000, 3'b001, 3'b111: reg_sel_base = BX;
            3'b010, 3'b011, 3'b110: reg_sel_base = BP;
            3'b100:                 reg_sel_base = SI;
            default:                reg_sel_base = DI;
        endcase

        case (modrm.rm)
            3'b000, 3'b010: reg_sel_index = SI;
            3'b001, 3'b011: reg_sel_index = DI;
            default:        reg_sel_index = AX; // no index.
        endcase
    end

    // r/m 100 and up use the base alone.
    always_comb begin
        case (modrm.mod)
            MOD_MEM: begin
                if (modrm.rm == RM_DIRECT) begin
                    effective_address = immediate;
                end else if (modrm.rm[2]) begin
                    effective_address = regs_base;
                end else begin
                    effective_address = regs_base + regs_index;
                end
            end
            MOD_DISP8, MOD_DISP16: begin
                if (modrm.rm[2]) begin
                    effective_address = regs_base + immediate;
                end else begin
                    effective_address = regs_base + regs_index + immediate;
                end
            end
            default: effective_address = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            have_modrm <= 1'b0;
            popped     <= 1'b0;
        end else begin
            popped <= fifo_rd_en;
            if (complete) begin
                have_modrm <= 1'b0;
            end else if (fifo_rd_en) begin
                have_modrm <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd_en) begin
            modrm <= modrm_t'(fifo_rd_data);
        end
    end

    a_start_held: assert property (
        @(posedge clk) disable iff (reset) busy && !complete |=> start
    );

endmodule

`default_nettype wire

//--- hw/address_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "modrm_consts.svh"

module address_regfile
    import cpu_regs_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   wr_en,
    input  wire reg_num_t               wr_sel,
    input  wire logic [`ADDR_WIDTH-1:0] wr_data,
    input  wire reg_num_t               sel_base,
    input  wire reg_num_t               sel_index,
    output logic [`ADDR_WIDTH-1:0]      rd_base,
    output logic [`ADDR_WIDTH-1:0]      rd_index
);

    logic [`ADDR_WIDTH-1:0] regs [8];

    // reads see the value before a same-cycle write.
    assign rd_base  = regs[sel_base];
    assign rd_index = regs[sel_index];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/immediate_reader.sv
`timescale 1ns/100ps
`default_nettype none

`include "modrm_consts.svh"

module immediate_reader (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   start,
    input  wire logic                   is_8bit,
    output logic                        fifo_rd_en,
    input  wire logic [`BYTE_WIDTH-1:0] fifo_rd_data,
    input  wire logic                   fifo_empty,
    output logic                        complete,
    output logic [`ADDR_WIDTH-1:0]      immediate
);

    typedef enum logic [1:0] {IDLE, READ_LO, READ_HI} state_t;

    state_t                 state;
    state_t                 state_next;
    logic                   is_8bit_q;
    logic [`BYTE_WIDTH-1:0] lo_byte;
    logic                   take_lo;
    logic                   take_hi;
    logic                   use_8bit;
    logic                   last_pop;

    assign use_8bit   = (state == IDLE) ? is_8bit : is_8bit_q;
    assign take_lo    = ((state == IDLE) && start) || (state == READ_LO);
    assign take_hi    = state == READ_HI;
    assign fifo_rd_en = (take_lo || take_hi) && !fifo_empty;
    assign last_pop   = fifo_rd_en && (take_hi || use_8bit);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (start) state_next = fifo_empty ? READ_LO : (is_8bit ? IDLE : READ_HI);
            READ_LO: if (!fifo_empty) state_next = is_8bit_q ? IDLE : READ_HI;
            READ_HI: if (!fifo_empty) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            complete <= 1'b0;
        end else begin
            state    <= state_next;
            complete <= last_pop; // one cycle after the last byte.
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_8bit_q <= is_8bit;
        end
        if (fifo_rd_en && take_lo) begin
            lo_byte <= fifo_rd_data;
        end
        if (last_pop) begin
            immediate <= take_hi ? {fifo_rd_data, lo_byte} :
                {{(`ADDR_WIDTH-`BYTE_WIDTH){fifo_rd_data[`BYTE_WIDTH-1]}}, fifo_rd_data};
        end
    end

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (reset) start |-> state == IDLE
    );

endmodule

`default_nettype wire

//--- hw/byte_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "modrm_consts.svh"

module byte_fifo (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   wr_en,
    input  wire logic [`BYTE_WIDTH-1:0] wr_data,
    output logic                        full,
    input  wire logic                   rd_en,
    output logic [`BYTE_WIDTH-1:0]      rd_data,
    output logic                        empty
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    logic [`BYTE_WIDTH-1:0] mem [`FIFO_DEPTH];
    logic [PTR_W:0]         wr_ptr;
    logic [PTR_W:0]         rd_ptr;
    logic                   do_write;
    logic                   do_read;

    assign do_write = wr_en && !full; // dropped when full.
    assign do_read  = rd_en && !empty;

    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // show-ahead head byte.
    assign rd_data = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[PTR_W-1:0]] <= wr_data;
        end
    end

    // consumers only pop a byte that is there.
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset) empty |-> !rd_en
    );

endmodule

`default_nettype wire

//--- hw/modrm_pkg.sv
`default_nettype none

package modrm_pkg;

    typedef logic [1:0] mod_t;
    typedef logic [2:0] reg_field_t;
    typedef logic [2:0] rm_t;

    typedef struct packed {
        mod_t       mod;
        reg_field_t reg_op; // reg or opcode extension.
        rm_t        rm;
    } modrm_t;

    localparam mod_t MOD_MEM    = 2'b00;
    localparam mod_t MOD_DISP8  = 2'b01;
    localparam mod_t MOD_DISP16 = 2'b10;
    localparam mod_t MOD_REG    = 2'b11;

    localparam rm_t RM_DIRECT = 3'b110; // disp16 only when mod is 00.

endpackage

`default_nettype wire

//--- hw/cpu_regs_pkg.sv
`default_nettype none

package cpu_regs_pkg;

    typedef logic [2:0] reg_num_t;

    // 16-bit general register encodings.
    localparam reg_num_t AX = 3'd0;
    localparam reg_num_t CX = 3'd1;
    localparam reg_num_t DX = 3'd2;
    localparam reg_num_t BX = 3'd3;
    localparam reg_num_t SP = 3'd4;
    localparam reg_num_t BP = 3'd5;
    localparam reg_num_t SI = 3'd6;
    localparam reg_num_t DI = 3'd7;

endpackage

`default_nettype wire

//--- hw/modrm_consts.svh
`ifndef MODRM_CONSTS_SVH
`define MODRM_CONSTS_SVH

// prefetch queue entries, power of two.
`define FIFO_DEPTH 8

// address and general register width.
`define ADDR_WIDTH 16

`define BYTE_WIDTH 8

`endif
